// ==== all.f ====
+incdir+include
rtl/isobus_pkg.sv
rtl/frame_timer.sv
rtl/shift_serializer.sv
rtl/shift_deserializer.sv
rtl/cs_sequencer.sv
rtl/isobus_link.sv
testbench/tb_isobus_link.sv

// ==== Makefile ====
# Verilator build and run for the isolated-bus link testbench

VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       = tb_isobus_link
FILELIST  = all.f
OBJ_DIR   = obj_dir
LOG       = sim.log
PASS_MSG  = Simulation finished: PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The log decides the result, the simulator status only feeds the log
run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "Run passed"; \
	else \
		echo "Run failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== include/isobus_tb_checks.svh ====
// Compare tasks for the isolated-bus link testbench
// Each check reports the first mismatch with its time and stops the run

`ifndef ISOBUS_TB_CHECKS_SVH
`define ISOBUS_TB_CHECKS_SVH

import isobus_pkg::*;

// Error line, fail line, then stop
task automatic report_error(input string msg);
    $display("[ERROR] %0t: %s", $time, msg);
    $display("Simulation finished: FAIL");
    $fatal(1, "%s", msg);
endtask

task automatic check_word(input frame_word_t got, input frame_word_t exp, input string what);
    if (got !== exp) begin
        report_error($sformatf("%s: got %02h, expected %02h", what, got, exp));
    end
endtask

task automatic check_mask(input port_mask_t got, input port_mask_t exp, input string what);
    if (got !== exp) begin
        report_error($sformatf("%s: got %04b, expected %04b", what, got, exp));
    end
endtask

task automatic check_ovf(input ovf_bits_t got, input ovf_bits_t exp, input string what);
    if (got !== exp) begin
        report_error($sformatf("%s: got %08b, expected %08b", what, got, exp));
    end
endtask

// Single-bit levels and strobes
task automatic check_strobe(input logic got, input logic exp, input string what);
    if (got !== exp) begin
        report_error($sformatf("%s: got %b, expected %b", what, got, exp));
    end
endtask

`endif

// ==== testbench/tb_isobus_link.sv ====
// Testbench for the isolated-bus sideband link
// Drives random status bits, settings and chip-select requests, decodes
// the serial frames and compares them with a reference model

`timescale 1ns/1ps

module tb_isobus_link import isobus_pkg::*; ();

    `include "isobus_tb_checks.svh"

    localparam int CLK_PERIOD_NS = 40;
    localparam int RESET_CYCLES = 2;
    localparam int NUM_FRAMES = 64;
    localparam int NUM_ACCESSES = 6;
    localparam int WATCHDOG_NS = (NUM_FRAMES + 20) * FRAME_BITS * CLK_PERIOD_NS;

    // Frame kinds known to the reference model
    localparam int KIND_CS = 0;
    localparam int KIND_CLKSEL = 1;
    localparam int KIND_HWCON = 2;

    // Access phase as seen on the decoded chip-select frames
    localparam int PH_IDLE = 0;
    localparam int PH_WAIT_SELECT = 1;
    localparam int PH_SELECTED = 2;
    localparam int PH_RELEASING = 3;

    logic        custom_srclk;
    logic        reset;
    port_mask_t  clksel;
    hwcon_bank_t hwcons;
    logic        spi_start;
    port_id_t    spi_port;
    logic        spi_done;
    logic        spi_busy;
    logic        custom_adc_ovf;
    logic        custom_dirchan;
    ovf_bits_t   aovf;
    port_mask_t  direction;
    port_mask_t  num_channels;
    logic        sr_load;
    logic        spi_adc_cs;
    logic        spi_dac_cs;
    logic        custom_clksel;
    logic        custom_adc_hwcon;

    integer      seed;
    integer      rnd;
    integer      rnd_bank;
    port_id_t    req_ports [NUM_ACCESSES];
    int          req_gaps [NUM_ACCESSES];

    // Model and decoder state, owned by the compare process
    logic        prev_reset = 1'b1;
    logic        prev_load = 1'b0;
    logic        collecting = 1'b0;
    logic        exp_load;
    int          edges = 0;
    int          rx_bits = 0;
    int          frames_checked = 0;
    int          accesses_done = 0;
    int          cs_phase = PH_IDLE;
    frame_word_t rx_adc = '0;
    frame_word_t rx_dac = '0;
    frame_word_t rx_clk = '0;
    frame_word_t rx_hw = '0;
    port_mask_t  pend_clksel = '0;
    port_mask_t  frm_clksel = '0;
    hwcon_bank_t pend_hwcons = '0;
    hwcon_bank_t frm_hwcons = '0;
    frame_word_t ovf_hist = '0;
    frame_word_t dirchan_hist = '0;
    ovf_bits_t   exp_ovf = '0;
    frame_word_t exp_dirchan = '0;
    port_id_t    acc_port = '0;
    logic        acc_dir = 1'b0;

    isobus_link isobus_link_inst (
        .custom_srclk     (custom_srclk),
        .reset            (reset),
        .clksel           (clksel),
        .hwcons           (hwcons),
        .spi_start        (spi_start),
        .spi_port         (spi_port),
        .spi_done         (spi_done),
        .spi_busy         (spi_busy),
        .custom_adc_ovf   (custom_adc_ovf),
        .custom_dirchan   (custom_dirchan),
        .aovf             (aovf),
        .direction        (direction),
        .num_channels     (num_channels),
        .sr_load          (sr_load),
        .spi_adc_cs       (spi_adc_cs),
        .spi_dac_cs       (spi_dac_cs),
        .custom_clksel    (custom_clksel),
        .custom_adc_hwcon (custom_adc_hwcon)
    );

    // Expected frame word for one serial line
    function automatic frame_word_t ref_frame(input int kind, input port_mask_t mask,
                                              input hwcon_bank_t bank, input int frame_num);
        frame_word_t w;
        case (kind)
            KIND_CS: w = {4'b0000, ~mask};
            KIND_CLKSEL: w = {4'b0000, mask};
            default: w = bank[(frame_num % NUM_PORTS) * FRAME_BITS +: FRAME_BITS];
        endcase
        return w;
    endfunction

    // Chip-select frames follow idle, selected, idle around each access
    task automatic check_cs_frame();
        port_mask_t port_bit;
        port_mask_t sel_adc;
        port_mask_t sel_dac;
        frame_word_t idle_word;
        logic is_sel;
        port_bit = '0;
        port_bit[acc_port] = 1'b1;
        sel_adc = acc_dir ? port_bit : '0;
        sel_dac = acc_dir ? '0 : port_bit;
        idle_word = ref_frame(KIND_CS, '0, '0, 0);
        is_sel = (rx_adc == ref_frame(KIND_CS, sel_adc, '0, 0)) &&
                 (rx_dac == ref_frame(KIND_CS, sel_dac, '0, 0));
        if (cs_phase == PH_SELECTED || (is_sel && cs_phase != PH_IDLE)) begin
            check_word(rx_adc, ref_frame(KIND_CS, sel_adc, '0, 0), "ADC chip-select frame");
            check_word(rx_dac, ref_frame(KIND_CS, sel_dac, '0, 0), "DAC chip-select frame");
            if (cs_phase == PH_WAIT_SELECT) begin
                cs_phase = PH_SELECTED;
            end
        end else begin
            check_word(rx_adc, idle_word, "idle ADC chip-select frame");
            check_word(rx_dac, idle_word, "idle DAC chip-select frame");
            if (cs_phase == PH_RELEASING) begin
                check_strobe(spi_busy, 1'b0, "spi_busy after release");
                cs_phase = PH_IDLE;
                accesses_done = accesses_done + 1;
            end
        end
    endtask

    task automatic check_frame();
        check_word(rx_clk, ref_frame(KIND_CLKSEL, frm_clksel, '0, 0), "clock-select frame");
        check_word(rx_hw, ref_frame(KIND_HWCON, '0, frm_hwcons, frames_checked),
                   "hardware-configuration frame");
        check_cs_frame();
        frames_checked = frames_checked + 1;
    endtask

    // One request, a dropped request while busy, then done
    task automatic run_access(input port_id_t port, input int gap);
        repeat (gap) @(posedge custom_srclk);
        spi_start <= 1'b1;
        spi_port <= port;
        @(posedge custom_srclk);
        spi_start <= 1'b0;
        while (!spi_busy) @(posedge custom_srclk);
        spi_start <= 1'b1;
        spi_port <= port + 2'd1;
        @(posedge custom_srclk);
        spi_start <= 1'b0;
        wait (cs_phase == PH_SELECTED);
        @(posedge custom_srclk);
        spi_done <= 1'b1;
        @(posedge custom_srclk);
        spi_done <= 1'b0;
        wait (cs_phase == PH_IDLE);
    endtask

    initial begin
        custom_srclk = 1'b0;
        forever #(CLK_PERIOD_NS / 2) custom_srclk = ~custom_srclk;
    end

    // Random status bits every cycle, settings right after each load
    initial begin
        seed = 32'h043b_25ad;
        for (int i = 0; i < NUM_ACCESSES; i++) begin
            rnd = $random(seed);
            req_ports[i] = rnd[1:0];
            req_gaps[i] = 2 + int'(rnd[7:4]);
        end
        rnd = $random(seed);
        rnd_bank = $random(seed);
        clksel <= rnd[3:0];
        hwcons <= rnd_bank;
        custom_adc_ovf <= 1'b0;
        custom_dirchan <= 1'b0;
        forever begin
            @(posedge custom_srclk);
            rnd = $random(seed);
            custom_adc_ovf <= rnd[0];
            custom_dirchan <= rnd[1];
            if (sr_load) begin
                rnd_bank = $random(seed);
                clksel <= rnd[7:4];
                hwcons <= rnd_bank;
            end
        end
    end

    initial begin
        reset <= 1'b1;
        spi_start <= 1'b0;
        spi_port <= '0;
        spi_done <= 1'b0;
        repeat (RESET_CYCLES) @(posedge custom_srclk);
        reset <= 1'b0;
        for (int i = 0; i < NUM_ACCESSES; i++) begin
            run_access(req_ports[i], req_gaps[i]);
        end
        wait (frames_checked >= NUM_FRAMES);
        @(posedge custom_srclk);
        if (accesses_done == NUM_ACCESSES) begin
            $display("Simulation finished: PASS");
            $finish;
        end else begin
            $display("Only %0d of %0d accesses completed", accesses_done, NUM_ACCESSES);
            $display("Simulation finished: FAIL");
            $fatal(1, "access count mismatch");
        end
    end

    // Sample on the falling edge, where every output is settled
    always @(negedge custom_srclk) begin
        edges = prev_reset ? 0 : edges + 1;
        exp_load = (edges != 0) && ((edges % FRAME_BITS) == 0);
        check_strobe(sr_load, exp_load, "sr_load");
        check_ovf(aovf, exp_ovf, "aovf");
        check_mask(num_channels, exp_dirchan[FRAME_BITS-1 -: NUM_PORTS], "num_channels");
        check_mask(direction, exp_dirchan[NUM_PORTS-1:0], "direction");
        if (cs_phase == PH_IDLE) begin
            check_strobe(spi_busy, 1'b0, "spi_busy between accesses");
        end else if (cs_phase != PH_RELEASING) begin
            check_strobe(spi_busy, 1'b1, "spi_busy during access");
        end
        // Sequencer reads the direction word published before this edge
        if (spi_start && !spi_busy) begin
            acc_port = spi_port;
            acc_dir = exp_dirchan[spi_port];
            cs_phase = PH_WAIT_SELECT;
        end
        if (spi_done && cs_phase == PH_SELECTED) begin
            cs_phase = PH_RELEASING;
        end
        if (prev_load) begin
            collecting = 1'b1;
            rx_bits = 0;
            frm_clksel = pend_clksel;
            frm_hwcons = pend_hwcons;
        end
        if (collecting) begin
            rx_adc = {rx_adc[FRAME_BITS-2:0], spi_adc_cs};
            rx_dac = {rx_dac[FRAME_BITS-2:0], spi_dac_cs};
            rx_clk = {rx_clk[FRAME_BITS-2:0], custom_clksel};
            rx_hw = {rx_hw[FRAME_BITS-2:0], custom_adc_hwcon};
            rx_bits = rx_bits + 1;
            if (rx_bits == FRAME_BITS) begin
                check_frame();
                collecting = 1'b0;
            end
        end
        // Bits driven now are sampled on the next rising edge
        ovf_hist = {ovf_hist[FRAME_BITS-2:0], custom_adc_ovf};
        dirchan_hist = {dirchan_hist[FRAME_BITS-2:0], custom_dirchan};
        if (sr_load) begin
            pend_clksel = clksel;
            pend_hwcons = hwcons;
            exp_ovf = ovf_hist;
            exp_dirchan = dirchan_hist;
        end
        prev_load = sr_load;
        prev_reset = reset;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout after %0d ns, frames or accesses stalled", WATCHDOG_NS);
        $display("Simulation finished: FAIL");
        $fatal(1, "watchdog expired");
    end

endmodule

// ==== rtl/isobus_link.sv ====
// Isolated-bus sideband link
// Serializes chip selects, clock selects and the rotating configuration
// byte to the converter board, and deserializes overflow and
// direction/channel bits coming back from it

`timescale 1ns/1ps

module isobus_link import isobus_pkg::*; (
    input  logic        custom_srclk,
    input  logic        reset,

    // Per-port settings
    input  port_mask_t  clksel,
    input  hwcon_bank_t hwcons,

    // Configuration access requests
    input  logic        spi_start,
    input  port_id_t    spi_port,
    input  logic        spi_done,
    output logic        spi_busy,

    // Status from the converter board
    input  logic        custom_adc_ovf,
    input  logic        custom_dirchan,
    output ovf_bits_t   aovf,
    output port_mask_t  direction,
    output port_mask_t  num_channels,

    // Shift-register pins
    output logic        sr_load,
    output logic        spi_adc_cs,
    output logic        spi_dac_cs,
    output logic        custom_clksel,
    output logic        custom_adc_hwcon
);

    port_id_t    hwcon_index;
    port_mask_t  adc_cs;
    port_mask_t  dac_cs;
    frame_word_t adc_cs_word;
    frame_word_t dac_cs_word;
    frame_word_t clksel_word;
    frame_word_t hwcon_word;
    frame_word_t dirchan_word;

    frame_timer frame_timer_inst (
        .custom_srclk (custom_srclk),
        .reset        (reset),
        .sr_load      (sr_load),
        .hwcon_index  (hwcon_index)
    );

    cs_sequencer cs_sequencer_inst (
        .custom_srclk (custom_srclk),
        .reset        (reset),
        .sr_load      (sr_load),
        .spi_start    (spi_start),
        .spi_port     (spi_port),
        .spi_done     (spi_done),
        .direction    (direction),
        .adc_cs       (adc_cs),
        .dac_cs       (dac_cs),
        .spi_busy     (spi_busy)
    );

    // Chip selects are active low on the bus
    assign adc_cs_word = {{PAD_BITS{1'b0}}, ~adc_cs};
    assign dac_cs_word = {{PAD_BITS{1'b0}}, ~dac_cs};
    assign clksel_word = {{PAD_BITS{1'b0}}, clksel};

    // One configuration byte per frame
    assign hwcon_word = hwcons[hwcon_index*FRAME_BITS +: FRAME_BITS];

    shift_serializer ser_adc_cs (
        .custom_srclk (custom_srclk),
        .reset        (reset),
        .sr_load      (sr_load),
        .word         (adc_cs_word),
        .serial       (spi_adc_cs)
    );

    shift_serializer ser_dac_cs (
        .custom_srclk (custom_srclk),
        .reset        (reset),
        .sr_load      (sr_load),
        .word         (dac_cs_word),
        .serial       (spi_dac_cs)
    );

    shift_serializer ser_clksel (
        .custom_srclk (custom_srclk),
        .reset        (reset),
        .sr_load      (sr_load),
        .word         (clksel_word),
        .serial       (custom_clksel)
    );

    shift_serializer ser_hwcon (
        .custom_srclk (custom_srclk),
        .reset        (reset),
        .sr_load      (sr_load),
        .word         (hwcon_word),
        .serial       (custom_adc_hwcon)
    );

    shift_deserializer deser_ovf (
        .custom_srclk (custom_srclk),
        .reset        (reset),
        .sr_load      (sr_load),
        .serial       (custom_adc_ovf),
        .word         (aovf)
    );

    shift_deserializer deser_dirchan (
        .custom_srclk (custom_srclk),
        .reset        (reset),
        .sr_load      (sr_load),
        .serial       (custom_dirchan),
        .word         (dirchan_word)
    );

    // High nibble channel counts, low nibble directions (1 = ADC)
    assign num_channels = dirchan_word[FRAME_BITS-1 -: NUM_PORTS];
    assign direction = dirchan_word[NUM_PORTS-1:0];

endmodule

// ==== rtl/cs_sequencer.sv ====
// Chip-select sequencer for converter configuration accesses
// Claims one ADC or DAC chip select on a frame boundary, holds it
// until the access is done and releases it on a later boundary

`timescale 1ns/1ps

module cs_sequencer import isobus_pkg::*; (
    input  logic       custom_srclk,
    input  logic       reset,
    input  logic       sr_load,
    input  logic       spi_start,
    input  port_id_t   spi_port,
    input  logic       spi_done,
    input  port_mask_t direction,
    output port_mask_t adc_cs,
    output port_mask_t dac_cs,
    output logic       spi_busy
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ARM,
        ST_SELECT,
        ST_RELEASE
    } cs_state_t;

    cs_state_t  state;
    port_id_t   port_q;
    logic       dir_q;
    logic       accept;
    port_mask_t port_bit;

    // Requests while busy are dropped
    assign accept = (state == ST_IDLE) && !spi_busy && spi_start;
    assign port_bit = port_mask_t'(1) << port_q;

    // Port and its bus direction are captured with the request
    always_ff @(posedge custom_srclk) begin
        if (accept) begin
            port_q <= spi_port;
            dir_q <= direction[spi_port];
        end
    end

    always_ff @(posedge custom_srclk or posedge reset) begin
        if (reset) begin
            state <= ST_IDLE;
            adc_cs <= '0;
            dac_cs <= '0;
            spi_busy <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    // Busy drops one cycle after the release boundary
                    if (spi_busy) begin
                        spi_busy <= 1'b0;
                    end else if (spi_start) begin
                        spi_busy <= 1'b1;
                        state <= ST_ARM;
                    end
                end
                ST_ARM: begin
                    if (sr_load) begin
                        // 1 = ADC bus, 0 = DAC bus
                        if (dir_q) begin
                            adc_cs <= port_bit;
                        end else begin
                            dac_cs <= port_bit;
                        end
                        state <= ST_SELECT;
                    end
                end
                ST_SELECT: begin
                    if (spi_done) begin
                        state <= ST_RELEASE;
                    end
                end
                ST_RELEASE: begin
                    if (sr_load) begin
                        adc_cs <= '0;
                        dac_cs <= '0;
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Only one converter bus is selected at a time
    a_one_bus: assert property (
        @(posedge custom_srclk) disable iff (reset)
        !((|adc_cs) && (|dac_cs))
    ) else $error("ADC and DAC chip selects active together");

    a_one_port: assert property (
        @(posedge custom_srclk) disable iff (reset)
        $onehot0(adc_cs) && $onehot0(dac_cs)
    ) else $error("more than one chip select bit set");

    a_busy_cover: assert property (
        @(posedge custom_srclk) disable iff (reset)
        (state != ST_IDLE) |-> spi_busy
    ) else $error("spi_busy low during an access");

endmodule

// ==== rtl/shift_deserializer.sv ====
// Serial-in, parallel-out shift register for one frame word
// Samples one bit per cycle and publishes the last eight at sr_load,
// with the first-sampled bit in the MSB

`timescale 1ns/1ps

module shift_deserializer import isobus_pkg::*; (
    input  logic        custom_srclk,
    input  logic        reset,
    input  logic        sr_load,
    input  logic        serial,
    output frame_word_t word
);

    frame_word_t shift_reg;
    frame_word_t next_shift;

    // Bits enter at the low end
    assign next_shift = {shift_reg[FRAME_BITS-2:0], serial};

    always_ff @(posedge custom_srclk or posedge reset) begin
        if (reset) begin
            shift_reg <= '0;
        end else begin
            shift_reg <= next_shift;
        end
    end

    // Holding register also takes the bit sampled on the load edge
    always_ff @(posedge custom_srclk or posedge reset) begin
        if (reset) begin
            word <= '0;
        end else if (sr_load) begin
            word <= next_shift;
        end
    end

endmodule

// ==== rtl/shift_serializer.sv ====
// Parallel-in, serial-out shift register for one frame word
// Loads at the frame boundary and sends the word MSB first

`timescale 1ns/1ps

module shift_serializer import isobus_pkg::*; (
    input  logic        custom_srclk,
    input  logic        reset,
    input  logic        sr_load,
    input  frame_word_t word,
    output logic        serial
);

    frame_word_t shift_reg;

    // The line starts low after reset
    always_ff @(posedge custom_srclk or posedge reset) begin
        if (reset) begin
            shift_reg <= '0;
        end else if (sr_load) begin
            shift_reg <= word;
        end else begin
            // Zeros fill in behind the outgoing bits
            shift_reg <= {shift_reg[FRAME_BITS-2:0], 1'b0};
        end
    end

    assign serial = shift_reg[FRAME_BITS-1];

endmodule

// ==== rtl/frame_timer.sv ====
// Frame timer for the isolated-bus shift registers
// Counts bit positions, issues the sr_load strobe at each frame boundary
// and steps the hardware-configuration rotation index once per frame

`timescale 1ns/1ps

module frame_timer import isobus_pkg::*; (
    input  logic     custom_srclk,
    input  logic     reset,
    output logic     sr_load,
    output port_id_t hwcon_index
);

    frame_count_t bit_count;

    // Bit counter wraps naturally after the last position
    always_ff @(posedge custom_srclk or posedge reset) begin
        if (reset) begin
            bit_count <= '0;
            sr_load <= 1'b0;
        end else begin
            bit_count <= bit_count + 1'b1;
            sr_load <= (bit_count == FRAME_LAST);
        end
    end

    // Configuration byte rotates through the ports once per frame
    always_ff @(posedge custom_srclk or posedge reset) begin
        if (reset) begin
            hwcon_index <= '0;
        end else if (sr_load) begin
            hwcon_index <= hwcon_index + 1'b1;
        end
    end

    // Strobe is a single-cycle pulse
    a_sr_load_single: assert property (
        @(posedge custom_srclk) disable iff (reset)
        sr_load |=> !sr_load
    ) else $error("sr_load high for two consecutive cycles");

endmodule

// ==== rtl/isobus_pkg.sv ====
// Isolated-bus sideband link definitions
// Frame geometry and the vector types shared by the link blocks

package isobus_pkg;

    // Bits per serial frame, one word per frame
    localparam int FRAME_BITS = 8;

    // Converter ports on the isolated bus
    localparam int NUM_PORTS = 4;

    // Zero bits ahead of a per-port mask inside a frame word
    localparam int PAD_BITS = FRAME_BITS - NUM_PORTS;

    localparam int COUNT_BITS = $clog2(FRAME_BITS);
    localparam int PORT_ID_BITS = $clog2(NUM_PORTS);

    // One serial frame word, sent and received MSB first
    typedef logic [FRAME_BITS-1:0] frame_word_t;

    // Bit position within a frame
    typedef logic [COUNT_BITS-1:0] frame_count_t;

    // Last bit position of a frame, where the load strobe is issued
    localparam frame_count_t FRAME_LAST = frame_count_t'(FRAME_BITS - 1);

    // One bit per port: chip selects, clock selects, directions, channel counts
    typedef logic [NUM_PORTS-1:0] port_mask_t;

    // Port number
    typedef logic [PORT_ID_BITS-1:0] port_id_t;

    // Hardware configuration bytes, port 0 in the low byte
    typedef logic [NUM_PORTS*FRAME_BITS-1:0] hwcon_bank_t;

    // ADC overflow flags
    // R3 L3 R2 L2 R1 L1 R0 L0 from high to low
    typedef logic [FRAME_BITS-1:0] ovf_bits_t;

endpackage
